// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the telemetry testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module bikeTelemetryTb -f sim.f -o simTb \
	&& ./obj_dir/simTb +verilator+error+limit+1000 2>&1 | tee sim.log \
	|| { echo "Build or simulation error"; exit 1; }

grep -q "Testbench failed" sim.log && exit 1 || exit 0

// ==== sim.f ====
source/bikePkg.sv
source/telemetryFramer.sv
source/byteFifo.sv
source/uartTransmitter.sv
source/bikeTelemetry.sv
tests/bikeTelemetry_chk.sv
tests/bikeTelemetryTb.sv

// ==== source/bikePkg.sv ====
// Shared types for the bike telemetry path
// Sensor widths, the sample snapshot and the frame layout

package bikePkg;

	// One byte on the FIFO and the serial line
	typedef logic [7:0] byte_t;

	// Resolved tilt angle from the fusion block
	typedef logic [9:0] angle_t;

	// Wheel speed reading
	typedef logic [7:0] speed_t;

	// Heart rate and heart-rate cap, beats per minute
	typedef logic [7:0] heart_t;

	// Readings captured together at each frame start, 34 bits
	typedef struct packed {
		angle_t angle;		// Upper field
		speed_t speed;
		heart_t heartRate;
		heart_t heartCap;	// Lowest byte
	} telemetrySample_t;

	// Sync byte leading every frame
	localparam byte_t FrameStart = 8'hA5;

	// Start, angle high, angle low, speed, heart rate, cap, checksum
	localparam int FrameBytes = 7;

endpackage

// ==== source/bikeTelemetry.sv ====
// Telemetry path top level
// Framer feeds the byte FIFO, the UART drains it onto the phone link

`timescale 1ns/1ps

module bikeTelemetry #(
	parameter int FramePeriod = 500000,	// Clocks between frames
	parameter int FifoDepth = 16,		// Bytes of buffering
	parameter int ClksPerBit = 434		// UART bit time
) (
	input	logic						CLOCK_50,
	input	logic						rst,
	input	bikePkg::telemetrySample_t	sample,		// Live readings
	output	logic						tx,			// To the phone module
	output	logic						txBusy
);

	import bikePkg::*;

	// Framer to FIFO
	logic	push;
	byte_t	pushData;
	logic	full;

	// FIFO to UART
	logic	pop;
	byte_t	popData;
	logic	empty;

	telemetryFramer #(
		.FramePeriod(FramePeriod)
	) i_telemetryFramer (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.sample(sample),
		.full(full),
		.push(push),
		.pushData(pushData)
	);

	byteFifo #(
		.FifoDepth(FifoDepth)
	) i_byteFifo (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.push(push),
		.pushData(pushData),
		.pop(pop),
		.popData(popData),
		.full(full),
		.empty(empty)
	);

	uartTransmitter #(
		.ClksPerBit(ClksPerBit)
	) i_uartTransmitter (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.popData(popData),
		.empty(empty),
		.pop(pop),
		.tx(tx),
		.txBusy(txBusy)
	);

endmodule

// ==== source/byteFifo.sv ====
// Circular byte FIFO between the framer and the UART
// Push and pop strobes, full and empty levels, head byte always on popData

`timescale 1ns/1ps

module byteFifo #(
	parameter int FifoDepth = 16	// Power of two, at least 2
) (
	input	logic				CLOCK_50,
	input	logic				rst,
	input	logic				push,
	input	bikePkg::byte_t		pushData,
	input	logic				pop,
	output	bikePkg::byte_t		popData,	// Valid while empty is low
	output	logic				full,
	output	logic				empty
);

	import bikePkg::*;

	localparam int AddrW = $clog2(FifoDepth);

	byte_t				mem [FifoDepth];
	logic [AddrW:0]		wrPtr;		// Extra bit tells full from empty
	logic [AddrW:0]		rdPtr;
	logic				doWrite;
	logic				doRead;

	// Guard against overflow and underflow
	assign doWrite = push && !full;
	assign doRead = pop && !empty;

	assign empty = (wrPtr == rdPtr);
	assign full = (wrPtr[AddrW] != rdPtr[AddrW]) &&
		(wrPtr[AddrW-1:0] == rdPtr[AddrW-1:0]);	// Wrapped once more than read

	// Head of queue
	assign popData = mem[rdPtr[AddrW-1:0]];

	// Storage
	always_ff @(posedge CLOCK_50) begin
		if (doWrite) begin
			mem[wrPtr[AddrW-1:0]] <= pushData;
		end
	end

	// Pointers
	// Push and pop in one cycle move both
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (doWrite) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doRead) begin
				rdPtr <= rdPtr + 1'b1;
			end
		end
	end

endmodule

// ==== source/telemetryFramer.sv ====
// Telemetry frame builder
// Snapshots the readings on a fixed period and pushes a checksummed byte frame

`timescale 1ns/1ps

module telemetryFramer #(
	parameter int FramePeriod = 500000	// Clocks between frame starts, at least FrameBytes + 1
) (
	input	logic						CLOCK_50,
	input	logic						rst,		// Sync, active high
	input	bikePkg::telemetrySample_t	sample,		// Live readings
	input	logic						full,		// FIFO back-pressure
	output	logic						push,		// One strobe per byte
	output	bikePkg::byte_t				pushData
);

	import bikePkg::*;

	localparam int CntW = $clog2(FramePeriod);
	localparam int IdxW = $clog2(FrameBytes);

	typedef enum logic {
		idle,
		sending
	} framerState_t;

	framerState_t		state;
	logic [CntW-1:0]	periodCnt;
	logic [IdxW-1:0]	byteIdx;		// Position inside the frame
	telemetrySample_t	snap;			// Readings held for the whole frame
	byte_t				checksum;		// XOR of payload bytes so far
	logic				periodDone;
	logic				capture;
	logic				lastByte;

	// Period expiry, only acted on between frames
	assign periodDone = (periodCnt == CntW'(FramePeriod - 1));
	assign capture = periodDone && (state == idle);
	assign lastByte = (byteIdx == IdxW'(FrameBytes - 1));

	// Byte goes out whenever there is room
	assign push = (state == sending) && !full;

	// Period counter
	// Holds at the terminal count while a frame is still going out
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			periodCnt <= '0;
		end else if (capture) begin
			periodCnt <= '0;	// Wrap on capture
		end else if (!periodDone) begin
			periodCnt <= periodCnt + 1'b1;
		end
	end

	// Frame state machine
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state <= idle;
			byteIdx <= '0;
		end else begin
			case (state)
				idle: begin
					if (capture) begin
						state <= sending;
						byteIdx <= '0;
					end
				end
				sending: begin
					if (push) begin
						if (lastByte) begin
							state <= idle;		// Checksum just went out
							byteIdx <= '0;
						end else begin
							byteIdx <= byteIdx + 1'b1;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Snapshot of the readings, taken on the capture cycle
	always_ff @(posedge CLOCK_50) begin
		if (capture) begin
			snap <= sample;
		end
	end

	// Running checksum over bytes 2 to 6
	always_ff @(posedge CLOCK_50) begin
		if (capture) begin
			checksum <= '0;
		end else if (push && byteIdx != '0 && !lastByte) begin
			checksum <= checksum ^ pushData;
		end
	end

	// Frame byte select
	always_comb begin
		case (byteIdx)
			IdxW'(0): pushData = FrameStart;
			IdxW'(1): pushData = byte_t'(snap.angle[9:8]);	// Zero-extended
			IdxW'(2): pushData = snap.angle[7:0];
			IdxW'(3): pushData = snap.speed;
			IdxW'(4): pushData = snap.heartRate;
			IdxW'(5): pushData = snap.heartCap;
			default: pushData = checksum;		// Last byte
		endcase
	end

endmodule

// ==== source/uartTransmitter.sv ====
// UART transmitter for the phone link
// Pops one byte when idle and sends it as 8N1, LSB first

`timescale 1ns/1ps

module uartTransmitter #(
	parameter int ClksPerBit = 434	// 115200 baud from 50 MHz
) (
	input	logic				CLOCK_50,
	input	logic				rst,
	input	bikePkg::byte_t		popData,	// FIFO head
	input	logic				empty,
	output	logic				pop,		// One-cycle strobe
	output	logic				tx,			// Serial line, idles high
	output	logic				txBusy
);

	import bikePkg::*;

	localparam int ClkW = $clog2(ClksPerBit);

	typedef enum logic [1:0] {
		idle,
		start,
		data,
		stop
	} uartState_t;

	uartState_t			state;
	logic [ClkW-1:0]	clkCnt;		// Position inside the bit time
	logic [2:0]			bitIdx;		// Data bit being sent
	byte_t				shiftReg;
	logic				bitEnd;

	assign bitEnd = (clkCnt == ClkW'(ClksPerBit - 1));

	// Take a byte only between characters
	assign pop = (state == idle) && !empty;
	assign txBusy = (state != idle) || pop;	// Covers the pop cycle too

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state <= idle;
			tx <= 1'b1;
			clkCnt <= '0;
			bitIdx <= '0;
		end else begin
			clkCnt <= bitEnd ? '0 : clkCnt + 1'b1;
			case (state)
				idle: begin
					clkCnt <= '0;
					if (pop) begin
						state <= start;
						tx <= 1'b0;		// Start bit from next cycle
					end
				end
				start: begin
					if (bitEnd) begin
						state <= data;
						bitIdx <= '0;
						tx <= shiftReg[0];
					end
				end
				data: begin
					if (bitEnd) begin
						if (bitIdx == 3'd7) begin
							state <= stop;
							tx <= 1'b1;		// Stop bit
						end else begin
							bitIdx <= bitIdx + 1'b1;
							tx <= shiftReg[0];
						end
					end
				end
				stop: begin
					if (bitEnd) begin
						state <= idle;	// Line stays high
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Shift register, loaded at pop and moved once per data bit
	always_ff @(posedge CLOCK_50) begin
		if (pop) begin
			shiftReg <= popData;
		end else if (bitEnd && (state == start || state == data)) begin
			shiftReg <= shiftReg >> 1;
		end
	end

endmodule

// ==== tests/bikeTelemetryTb.sv ====
// Testbench for the bike telemetry path
// Decodes the serial stream and checks each frame against the driven readings

`timescale 1ns/1ps

module bikeTelemetryTb;

	import bikePkg::*;

	localparam int FramePeriod = 24;	// Far shorter than one UART character
	localparam int FifoDepth = 4;
	localparam int ClksPerBit = 8;
	localparam logic [31:0] Seed = 32'ha416_b4f3;
	localparam int EdgeTimeout = 2000;	// Clocks to wait for a start bit
	localparam int BusyTimeout = 200;	// Clocks from reset to first pop
	localparam int FramesRun = 8;

	logic				clk = 1'b0;
	logic				rst;
	telemetrySample_t	sample;
	logic				tx;
	logic				txBusy;

	telemetrySample_t	expQ[$];		// Readings expected at each capture
	int					errorCount = 0;
	logic				fullSeen = 1'b0;	// Back-pressure reached at least once

	bikeTelemetry #(
		.FramePeriod(FramePeriod),
		.FifoDepth(FifoDepth),
		.ClksPerBit(ClksPerBit)
	) i_bikeTelemetry (
		.CLOCK_50(clk),
		.rst(rst),
		.sample(sample),
		.tx(tx),
		.txBusy(txBusy)
	);

	always #10 clk = ~clk;	// 50 MHz

	always @(negedge clk) begin
		if (i_bikeTelemetry.full) begin
			fullSeen <= 1'b1;
		end
	end

	function automatic telemetrySample_t randomSample();
		telemetrySample_t s;
		s.angle = angle_t'($urandom_range(1023));
		s.speed = speed_t'($urandom_range(255));
		s.heartRate = heart_t'($urandom_range(255));
		s.heartCap = heart_t'($urandom_range(255));
		return s;
	endfunction

	task automatic finishRun();
		int assertFails;
		assertFails = i_bikeTelemetry.i_bikeTelemetryChk.failCount;
		$display("Run complete: %0d check errors, %0d assertion failures", errorCount,
			assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	task automatic checkValue(input string name, input byte_t expected, input byte_t actual);
		assert (actual == expected) else begin
			$display("ERROR %s: expected %02h, actual %02h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		assert (actual === expected) else begin
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
			errorCount++;
		end
	endtask

	// Line must stay quiet until the first pop
	task automatic checkIdleUntilFrame(input string name);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!txBusy) begin
			checkBit({name, " tx"}, 1'b1, tx);
			@(negedge clk);
			waited++;
			if (waited > BusyTimeout) begin
				$display("Timeout: transmitter never started after %s", name);
				errorCount++;
				finishRun();
			end
		end
	endtask

	// 8N1 receiver, samples mid bit on falling clock edges
	task automatic readByte(input string name, output byte_t data);
		int waited;
		int i;
		waited = 0;
		data = '0;
		while (tx !== 1'b0) begin
			@(negedge clk);
			waited++;
			if (waited > EdgeTimeout) begin
				$display("Timeout: no start bit on tx for %s", name);
				errorCount++;
				finishRun();
			end
		end
		repeat (ClksPerBit / 2) @(negedge clk);	// Middle of start bit
		checkBit({name, " start bit"}, 1'b0, tx);
		for (i = 0; i < 8; i++) begin
			repeat (ClksPerBit) @(negedge clk);
			data[i] = tx;		// LSB first
		end
		repeat (ClksPerBit) @(negedge clk);
		checkBit({name, " stop bit"}, 1'b1, tx);
	endtask

	// Inputs move while the frame is on the line, before the next capture
	task automatic changeSampleMidFrame();
		telemetrySample_t s;
		int changes;
		int n;
		changes = $urandom_range(3, 1);
		s = sample;
		for (n = 0; n < changes; n++) begin
			repeat ($urandom_range(16, 1)) @(posedge clk);
			s = randomSample();
			sample <= s;
		end
		expQ.push_back(s);	// Last value is what the next capture sees
	endtask

	task automatic readFrame(input int frameNo, input int byteCount, input bit changeInputs);
		telemetrySample_t s;
		byte_t expected [FrameBytes];
		byte_t got;
		byte_t runXor;
		string name;
		int idx;
		runXor = '0;
		s = sample;
		if (expQ.size() == 0) begin
			$display("No expected readings queued for frame %0d", frameNo);
			errorCount++;
		end else begin
			s = expQ.pop_front();
		end
		expected[0] = FrameStart;
		expected[1] = byte_t'(s.angle[9:8]);	// Upper angle bits
		expected[2] = s.angle[7:0];
		expected[3] = s.speed;
		expected[4] = s.heartRate;
		expected[5] = s.heartCap;
		expected[6] = expected[1] ^ expected[2] ^ expected[3] ^ expected[4] ^ expected[5];
		for (idx = 0; idx < byteCount; idx++) begin
			name = $sformatf("frame %0d byte %0d", frameNo, idx);
			readByte(name, got);
			checkValue(name, expected[idx], got);
			if (idx > 0 && idx < FrameBytes - 1) begin
				runXor = runXor ^ got;
			end
			if (idx == FrameBytes - 1) begin
				checkValue($sformatf("frame %0d checksum", frameNo), runXor, got);
			end
			if (idx == 0 && changeInputs) begin
				fork
					changeSampleMidFrame();
				join_none
			end
		end
	endtask

	initial begin
		int f;
		void'($urandom(Seed));
		rst = 1'b1;
		sample = randomSample();
		expQ.push_back(sample);		// First capture after reset
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		checkIdleUntilFrame("reset release");

		// Sustained back-pressure, frames back to back
		for (f = 0; f < FramesRun; f++) begin
			readFrame(f, FrameBytes, 1'b1);
		end
		assert (fullSeen) else begin
			$display("FIFO never reached full, back-pressure not exercised");
			errorCount++;
		end

		// Reset in the middle of a frame
		readFrame(FramesRun, 3, 1'b0);
		@(posedge clk);
		rst <= 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		expQ.delete();
		expQ.push_back(sample);
		@(negedge clk);
		checkBit("mid-frame reset tx", 1'b1, tx);
		checkBit("mid-frame reset txBusy", 1'b0, txBusy);
		checkIdleUntilFrame("mid-frame reset");
		for (f = FramesRun + 1; f < FramesRun + 4; f++) begin
			readFrame(f, FrameBytes, 1'b1);
		end

		finishRun();
	end

endmodule

// ==== tests/bikeTelemetry_chk.sv ====
// Bound checker for the telemetry top level
// FIFO flow control against full and empty, serial line idle and stop levels

`timescale 1ns/1ps

module bikeTelemetryChk (
	input	logic	CLOCK_50,
	input	logic	rst,
	input	logic	push,
	input	logic	full,
	input	logic	pop,
	input	logic	empty,
	input	logic	tx,
	input	logic	txBusy
);

	int failCount = 0;	// Read by the testbench at the end

	// Framer holds off while the FIFO has no room
	pushWhileFull: assert property (@(posedge CLOCK_50) disable iff (rst) !(push && full))
		else begin
			$error("push strobe while FIFO full");
			failCount = failCount + 1;
		end

	// UART takes a byte only when one is there
	popWhileEmpty: assert property (@(posedge CLOCK_50) disable iff (rst) !(pop && empty))
		else begin
			$error("pop strobe while FIFO empty");
			failCount = failCount + 1;
		end

	// Line idles high between characters
	idleLineHigh: assert property (@(posedge CLOCK_50) disable iff (rst) !txBusy |-> tx)
		else begin
			$error("tx low while transmitter idle");
			failCount = failCount + 1;
		end

	// Stop bit or idle level still on the line when the next byte is taken
	stopBitHigh: assert property (@(posedge CLOCK_50) disable iff (rst) pop |-> tx)
		else begin
			$error("tx not high when next byte popped");
			failCount = failCount + 1;
		end

	// Reset leaves the line quiet
	resetLevels: assert property (@(posedge CLOCK_50) $fell(rst) |-> (tx && !txBusy))
		else begin
			$error("tx or txBusy wrong on reset release");
			failCount = failCount + 1;
		end

endmodule

bind bikeTelemetry bikeTelemetryChk i_bikeTelemetryChk (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.push(push),
	.full(full),
	.pop(pop),
	.empty(empty),
	.tx(tx),
	.txBusy(txBusy)
);
